// ==== coreTypesPkg.sv ====
package coreTypesPkg;

    // data path width shared by the ROB, commit bus and register file
    parameter int dataWidth = 32;

    typedef logic [dataWidth-1:0] dataT;

    // architectural register space
    parameter int numArchRegs = 16;
    parameter int archRegWidth = $clog2(numArchRegs);

    typedef logic [archRegWidth-1:0] archRegT;

    // value returned on any lookup or commit slot that carries nothing
    parameter dataT dataFree = '0;

    // tag format:
    //   tag = {prefix, robIndex}
    //   prefix 0 names a ROB slot, prefix 1 means no tag (tagFree)
    // the tag width depends on robSize, so every module derives its own

endpackage

// ==== branchPkg.sv ====
package branchPkg;

    // branches that may be unresolved at the same time
    parameter int maxBranches = 4;

    // one bit per in-flight branch slot
    typedef logic [maxBranches-1:0] branchMaskT;

    // names a single branch slot
    typedef logic [$clog2(maxBranches)-1:0] branchIdxT;

endpackage

// ==== robIfs.sv ====
`timescale 1ns/1ns

// allocation path between the dispatch unit and the ROB
interface dispatchIf #(
    parameter int robSize = 8
);
    logic dispatchEn;
    branchPkg::branchMaskT dispBranchMask;
    coreTypesPkg::archRegT dispReg;
    // tail tag, the one the next dispatched entry receives
    logic [$clog2(robSize):0] freeTag;
    logic robFree;

    modport disp (
        output dispatchEn, dispBranchMask, dispReg,
        input  freeTag, robFree
    );

    modport rob (
        input  dispatchEn, dispBranchMask, dispReg,
        output freeTag, robFree
    );
endinterface

// in-order retirement path from the ROB head
interface commitIf #(
    parameter int robSize = 8
);
    logic commitValid;
    logic [$clog2(robSize):0] commitTag;
    coreTypesPkg::archRegT commitReg;
    coreTypesPkg::dataT commitData;

    modport rob (
        output commitValid, commitTag, commitReg, commitData
    );

    modport regs (
        input  commitValid, commitReg, commitData
    );
endinterface

// ==== dispatchUnit.sv ====
`timescale 1ns/1ns

module dispatchUnit #(
    parameter int robSize = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic instValid,
    input  coreTypesPkg::archRegT instReg,
    input  logic instIsBranch,
    output logic instReady,
    output logic [$clog2(robSize):0] issueTag,
    output branchPkg::branchIdxT issueBranchIdx,
    input  logic resolveValid,
    input  branchPkg::branchIdxT resolveIdx,
    input  logic resolveMiss,
    dispatchIf.disp disp
);
    branchPkg::branchMaskT busy;
    // per slot: older branches this branch itself depends on
    branchPkg::branchMaskT depMask [branchPkg::maxBranches];

    branchPkg::branchIdxT freeSlot;
    logic anyFree;
    branchPkg::branchMaskT resolveBit;
    branchPkg::branchMaskT freedMask;
    branchPkg::branchMaskT stampMask;
    logic wrongPath;
    logic accept;
    logic allocBranch;

    // lowest free branch slot
    always_comb begin
        anyFree = 1'b0;
        freeSlot = '0;
        for (int i = branchPkg::maxBranches - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                anyFree = 1'b1;
                freeSlot = branchPkg::branchIdxT'(i);
            end
        end
    end

    always_comb begin
        resolveBit = '0;
        if (resolveValid) begin
            resolveBit[resolveIdx] = 1'b1;
        end
        // a miss also releases every younger branch that depends on it
        freedMask = resolveBit;
        if (resolveValid && resolveMiss) begin
            for (int i = 0; i < branchPkg::maxBranches; i++) begin
                if (busy[i] && depMask[i][resolveIdx]) begin
                    freedMask[i] = 1'b1;
                end
            end
        end
    end

    // on a miss the bit stays in the stamp so the ROB drops the new entry
    assign stampMask = resolveMiss ? busy : (busy & ~resolveBit);
    assign wrongPath = resolveValid && resolveMiss && busy[resolveIdx];

    assign instReady = disp.robFree && (!instIsBranch || anyFree);
    assign accept = instValid && instReady;
    assign allocBranch = accept && instIsBranch && !wrongPath;

    assign disp.dispatchEn = accept;
    assign disp.dispBranchMask = stampMask;
    assign disp.dispReg = instReg;

    assign issueTag = disp.freeTag;
    assign issueBranchIdx = freeSlot;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            for (int i = 0; i < branchPkg::maxBranches; i++) begin
                depMask[i] <= '0;
            end
        end else begin
            for (int i = 0; i < branchPkg::maxBranches; i++) begin
                if (allocBranch && freeSlot == branchPkg::branchIdxT'(i)) begin
                    busy[i] <= 1'b1;
                    depMask[i] <= stampMask & ~freedMask;
                end else begin
                    busy[i] <= busy[i] & ~freedMask[i];
                    depMask[i] <= depMask[i] & ~freedMask;
                end
            end
        end
    end

endmodule

// ==== reorderBuffer.sv ====
`timescale 1ns/1ns

module reorderBuffer #(
    parameter int robSize = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic wbValid,
    input  logic [$clog2(robSize):0] wbTag,
    input  coreTypesPkg::dataT wbData,
    input  logic [$clog2(robSize):0] readTagA,
    input  logic [$clog2(robSize):0] readTagB,
    output logic readOkA,
    output logic readOkB,
    output coreTypesPkg::dataT readDataA,
    output coreTypesPkg::dataT readDataB,
    input  logic resolveValid,
    input  branchPkg::branchIdxT resolveIdx,
    input  logic resolveMiss,
    dispatchIf.rob disp,
    commitIf.rob commit
);
    localparam int idxWidth = $clog2(robSize);
    localparam int tagWidth = idxWidth + 1;
    localparam logic [tagWidth-1:0] tagFree = {1'b1, {idxWidth{1'b0}}};
    localparam logic [idxWidth:0] fullCount = (idxWidth + 1)'(robSize);

    // entry state
    logic [robSize-1:0] valid;
    logic [robSize-1:0] done;
    branchPkg::branchMaskT mask [robSize];
    coreTypesPkg::dataT data [robSize];
    coreTypesPkg::archRegT destReg [robSize];

    logic [idxWidth-1:0] head;
    logic [idxWidth-1:0] tail;
    // slots between head and tail including killed ones
    logic [idxWidth:0] count;

    logic [idxWidth-1:0] wbIdx;
    logic wbHit;
    branchPkg::branchMaskT resolveBit;
    logic [robSize-1:0] kill;
    logic newKilled;
    logic commitNow;
    logic headMove;

    assign disp.freeTag = {1'b0, tail};
    assign disp.robFree = (count != fullCount);

    assign wbIdx = wbTag[idxWidth-1:0];
    assign wbHit = wbValid && !wbTag[idxWidth] && valid[wbIdx];

    always_comb begin
        resolveBit = '0;
        if (resolveValid) begin
            resolveBit[resolveIdx] = 1'b1;
        end
    end

    // entries on the wrong side of a mispredicted branch
    always_comb begin
        for (int i = 0; i < robSize; i++) begin
            kill[i] = resolveValid && resolveMiss && mask[i][resolveIdx];
        end
    end

    // an entry dispatched under the branch that misses this cycle
    assign newKilled = resolveValid && resolveMiss && disp.dispBranchMask[resolveIdx];

    assign commitNow = (count != '0) && valid[head] && done[head] && (mask[head] == '0);
    assign headMove = (count != '0) && (!valid[head] || commitNow);

    // returns {ok, data} and prefers the bypass over the stored result
    function automatic logic [coreTypesPkg::dataWidth:0] lookup(
        input logic [tagWidth-1:0] tag
    );
        logic [idxWidth-1:0] idx;
        idx = tag[idxWidth-1:0];
        if (tag[idxWidth] || !valid[idx]) begin
            return {1'b0, coreTypesPkg::dataFree};
        end
        if (wbValid && wbTag == tag) begin
            return {1'b1, wbData};
        end
        if (done[idx]) begin
            return {1'b1, data[idx]};
        end
        return {1'b0, coreTypesPkg::dataFree};
    endfunction

    always_comb begin
        {readOkA, readDataA} = lookup(readTagA);
        {readOkB, readDataB} = lookup(readTagB);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            done <= '0;
            for (int i = 0; i < robSize; i++) begin
                mask[i] <= '0;
            end
        end else begin
            for (int i = 0; i < robSize; i++) begin
                if (disp.dispatchEn && tail == idxWidth'(i)) begin
                    valid[i] <= !newKilled;
                    done[i] <= 1'b0;
                    mask[i] <= disp.dispBranchMask & ~resolveBit;
                end else begin
                    mask[i] <= mask[i] & ~resolveBit;
                    if (headMove && head == idxWidth'(i)) begin
                        valid[i] <= 1'b0;
                    end else begin
                        valid[i] <= valid[i] & ~kill[i];
                    end
                    if (wbHit && wbIdx == idxWidth'(i)) begin
                        done[i] <= 1'b1;
                    end
                end
            end
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (wbHit) begin
            data[wbIdx] <= wbData;
        end
        if (disp.dispatchEn) begin
            destReg[tail] <= disp.dispReg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            // pointers wrap on their own since robSize is a power of two
            if (disp.dispatchEn) begin
                tail <= tail + 1'b1;
            end
            if (headMove) begin
                head <= head + 1'b1;
            end
            if (disp.dispatchEn && !headMove) begin
                count <= count + 1'b1;
            end else if (!disp.dispatchEn && headMove) begin
                count <= count - 1'b1;
            end
        end
    end

    // registered commit from the head
    always_ff @(posedge clk) begin
        if (rst) begin
            commit.commitValid <= 1'b0;
            commit.commitTag <= tagFree;
            commit.commitReg <= '0;
            commit.commitData <= coreTypesPkg::dataFree;
        end else if (commitNow) begin
            commit.commitValid <= 1'b1;
            commit.commitTag <= {1'b0, head};
            commit.commitReg <= destReg[head];
            commit.commitData <= data[head];
        end else begin
            commit.commitValid <= 1'b0;
            commit.commitTag <= tagFree;
            commit.commitReg <= '0;
            commit.commitData <= coreTypesPkg::dataFree;
        end
    end

endmodule

// ==== archRegFile.sv ====
`timescale 1ns/1ns

module archRegFile (
    input  logic clk,
    input  logic rst,
    commitIf.regs regs,
    input  coreTypesPkg::archRegT archReadReg,
    output coreTypesPkg::dataT archReadData
);
    coreTypesPkg::dataT regArray [coreTypesPkg::numArchRegs];

    // only retired results land here
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < coreTypesPkg::numArchRegs; i++) begin
                regArray[i] <= coreTypesPkg::dataFree;
            end
        end else if (regs.commitValid) begin
            regArray[regs.commitReg] <= regs.commitData;
        end
    end

    // no write-through, a commit shows up one edge later
    assign archReadData = regArray[archReadReg];

endmodule

// ==== robCore.sv ====
`timescale 1ns/1ns

module robCore #(
    parameter int robSize = 8
) (
    input  logic clk,
    input  logic rst,
    // instruction input
    input  logic instValid,
    input  coreTypesPkg::archRegT instReg,
    input  logic instIsBranch,
    output logic instReady,
    output logic [$clog2(robSize):0] issueTag,
    output branchPkg::branchIdxT issueBranchIdx,
    // writeback
    input  logic wbValid,
    input  logic [$clog2(robSize):0] wbTag,
    input  coreTypesPkg::dataT wbData,
    // operand lookups
    input  logic [$clog2(robSize):0] readTagA,
    input  logic [$clog2(robSize):0] readTagB,
    output logic readOkA,
    output logic readOkB,
    output coreTypesPkg::dataT readDataA,
    output coreTypesPkg::dataT readDataB,
    // branch resolution, shared by dispatch and ROB
    input  logic resolveValid,
    input  branchPkg::branchIdxT resolveIdx,
    input  logic resolveMiss,
    // commit
    output logic commitValid,
    output logic [$clog2(robSize):0] commitTag,
    output coreTypesPkg::archRegT commitReg,
    output coreTypesPkg::dataT commitData,
    // architectural read
    input  coreTypesPkg::archRegT archReadReg,
    output coreTypesPkg::dataT archReadData
);
    dispatchIf #(.robSize(robSize)) dispBus ();
    commitIf #(.robSize(robSize)) commitBus ();

    dispatchUnit #(.robSize(robSize)) dispatch (
        .clk            (clk),
        .rst            (rst),
        .instValid      (instValid),
        .instReg        (instReg),
        .instIsBranch   (instIsBranch),
        .instReady      (instReady),
        .issueTag       (issueTag),
        .issueBranchIdx (issueBranchIdx),
        .resolveValid   (resolveValid),
        .resolveIdx     (resolveIdx),
        .resolveMiss    (resolveMiss),
        .disp           (dispBus.disp)
    );

    reorderBuffer #(.robSize(robSize)) rob (
        .clk          (clk),
        .rst          (rst),
        .wbValid      (wbValid),
        .wbTag        (wbTag),
        .wbData       (wbData),
        .readTagA     (readTagA),
        .readTagB     (readTagB),
        .readOkA      (readOkA),
        .readOkB      (readOkB),
        .readDataA    (readDataA),
        .readDataB    (readDataB),
        .resolveValid (resolveValid),
        .resolveIdx   (resolveIdx),
        .resolveMiss  (resolveMiss),
        .disp         (dispBus.rob),
        .commit       (commitBus.rob)
    );

    archRegFile regFile (
        .clk          (clk),
        .rst          (rst),
        .regs         (commitBus.regs),
        .archReadReg  (archReadReg),
        .archReadData (archReadData)
    );

    assign commitValid = commitBus.commitValid;
    assign commitTag = commitBus.commitTag;
    assign commitReg = commitBus.commitReg;
    assign commitData = commitBus.commitData;

endmodule

// ==== tbRobCore.sv ====
`timescale 1ns/1ns

module tbRobCore;
    localparam int robSize = 8;
    localparam int tagW = $clog2(robSize) + 1;
    localparam logic [tagW-1:0] tagFree = {1'b1, {(tagW - 1){1'b0}}};

    // one live instruction of the reference model
    typedef struct {
        logic [tagW-1:0] tag;
        logic [3:0] dest;
        logic [31:0] data;
        logic [3:0] mask;
        bit done;
    } entryT;

    logic clk, rst;
    logic instValid, instIsBranch, instReady;
    logic [3:0] instReg, commitReg, archReadReg;
    logic [tagW-1:0] issueTag, wbTag, readTagA, readTagB, commitTag;
    logic [1:0] issueBranchIdx, resolveIdx;
    logic wbValid, readOkA, readOkB, resolveValid, resolveMiss, commitValid;
    logic [31:0] wbData, readDataA, readDataB, commitData, archReadData;

    entryT rob[$];
    logic [31:0] regModel [16];
    logic [3:0] busy;
    logic [3:0] depMask [4];
    logic [tagW-2:0] tail;
    logic [31:0] seed;
    logic [3:0] archPendReg;
    bit archPending, wantDisp, accepted;
    int errors, testErrors, testsRun, testsFailed;

    robCore #(.robSize(robSize)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        seed ^= seed << 13;
        seed ^= seed >> 17;
        seed ^= seed << 5;
        return seed;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch %s: expected %0h actual %0h", name, exp, act);
            errors++;
            testErrors++;
        end
    endtask

    task automatic reportFailure(input string name, input string msg);
        $display("%s: %s", name, msg);
        errors++;
        testErrors++;
    endtask

    task automatic clearInputs();
        instValid = 1'b0;
        instIsBranch = 1'b0;
        instReg = '0;
        wantDisp = 1'b0;
        wbValid = 1'b0;
        wbTag = tagFree;
        wbData = '0;
        resolveValid = 1'b0;
        resolveIdx = '0;
        resolveMiss = 1'b0;
        readTagA = tagFree;
        readTagB = tagFree;
    endtask

    // commits leave in dispatch order and the register file follows one edge later
    task automatic observe(input string name);
        entryT head;
        if (archPending) begin
            checkValue({name, " arch reg"}, regModel[archPendReg], archReadData);
            archPending = 1'b0;
        end
        if (commitValid) begin
            if (rob.size() == 0) begin
                reportFailure(name, "a commit appeared with no live entry left");
            end else begin
                head = rob.pop_front();
                checkValue({name, " commitTag"}, head.tag, commitTag);
                checkValue({name, " commitReg"}, head.dest, commitReg);
                checkValue({name, " commitData"}, head.data, commitData);
                checkValue({name, " commit ready"}, 1, head.done && head.mask == 0);
                regModel[head.dest] = head.data;
                archReadReg = head.dest;
                archPendReg = head.dest;
                archPending = 1'b1;
            end
        end
    endtask

    task automatic startCycle(input string name);
        @(negedge clk);
        observe(name);
        clearInputs();
    endtask

    task automatic checkLookup(input string name, input logic [tagW-1:0] tag, input logic ok,
                               input logic [31:0] data);
        logic expOk;
        logic [31:0] expData;
        expOk = 1'b0;
        expData = '0;
        foreach (rob[i]) begin
            if (rob[i].tag == tag) begin
                // same-cycle writeback wins over the stored value
                if (wbValid && wbTag == tag) begin
                    expOk = 1'b1;
                    expData = wbData;
                end else if (rob[i].done) begin
                    expOk = 1'b1;
                    expData = rob[i].data;
                end
            end
        end
        checkValue({name, " readOk"}, expOk, ok);
        checkValue({name, " readData"}, expData, data);
    endtask

    // settle the driven inputs, check them and step the model
    task automatic finishCycle(input string name);
        logic [3:0] freed;
        logic [1:0] slot;
        entryT e;
        instValid = wantDisp;
        #1;
        checkLookup({name, " lookup A"}, readTagA, readOkA, readDataA);
        checkLookup({name, " lookup B"}, readTagB, readOkB, readDataB);
        if (instIsBranch && busy == 4'hf)
            checkValue({name, " instReady"}, 0, instReady);
        accepted = wantDisp && instReady;
        if (wbValid) begin
            foreach (rob[i]) begin
                if (rob[i].tag == wbTag) begin
                    rob[i].done = 1'b1;
                    rob[i].data = wbData;
                end
            end
        end
        if (accepted) begin
            checkValue({name, " issueTag"}, {1'b0, tail}, issueTag);
            e = '{tag: {1'b0, tail}, dest: instReg, data: '0, mask: busy, done: 1'b0};
            rob.push_back(e);
            tail++;
            if (instIsBranch) begin
                slot = '0;
                for (int i = 3; i >= 0; i--)
                    if (!busy[i])
                        slot = 2'(i);
                checkValue({name, " issueBranchIdx"}, slot, issueBranchIdx);
                busy[slot] = 1'b1;
                depMask[slot] = e.mask;
            end
        end
        if (resolveValid) begin
            freed = 4'b0001 << resolveIdx;
            if (resolveMiss) begin
                // younger branches stamped with the missed one go too
                for (int i = 0; i < 4; i++)
                    if (busy[i] && depMask[i][resolveIdx])
                        freed[i] = 1'b1;
                for (int i = rob.size() - 1; i >= 0; i--)
                    if (rob[i].mask[resolveIdx])
                        rob.delete(i);
            end
            foreach (rob[i])
                rob[i].mask[resolveIdx] = 1'b0;
            busy &= ~freed;
            for (int i = 0; i < 4; i++)
                depMask[i] &= ~freed;
        end
    endtask

    task automatic pickPending(input logic [31:0] r);
        int pending[$];
        foreach (rob[i])
            if (!rob[i].done)
                pending.push_back(i);
        if (pending.size() != 0) begin
            wbValid = 1'b1;
            wbTag = rob[pending[r % pending.size()]].tag;
            wbData = nextRandom();
        end
    endtask

    task automatic resolveBusy(input logic [1:0] start, input logic miss);
        logic [1:0] idx;
        for (int i = 0; i < 4; i++) begin
            idx = 2'(start + i);
            if (busy[idx] && !resolveValid) begin
                resolveValid = 1'b1;
                resolveIdx = idx;
                resolveMiss = miss;
            end
        end
    endtask

    function automatic logic [tagW-1:0] liveTag(input logic [31:0] r);
        if (rob.size() == 0)
            return tagFree;
        return rob[r % rob.size()].tag;
    endfunction

    // finish all writebacks and branches until the model is empty
    task automatic drain(input string name);
        int guard;
        guard = 0;
        while ((rob.size() != 0 || busy != 0 || archPending) && guard < 300) begin
            startCycle(name);
            pickPending(nextRandom());
            resolveBusy(2'd0, 1'b0);
            finishCycle(name);
            guard++;
        end
        if (rob.size() != 0 || busy != 0 || archPending)
            reportFailure(name, "timed out waiting for the ROB to drain");
    endtask

    task automatic sweepRegs(input string name);
        for (int i = 0; i < 16; i++) begin
            startCycle(name);
            archReadReg = 4'(i);
            #1;
            checkValue({name, " arch sweep"}, regModel[i], archReadData);
        end
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (testErrors != 0)
            testsFailed++;
        $display("test %s: %s (%0d errors)", name, testErrors == 0 ? "ok" : "failed", testErrors);
        testErrors = 0;
    endtask

    task automatic backpressureTest();
        int guard;
        for (int i = 0; i < robSize + 2; i++) begin
            startCycle("backpressure");
            wantDisp = 1'b1;
            // four branches, one refused branch, then plain entries up to full
            instIsBranch = (i <= 4);
            instReg = 4'(i);
            finishCycle("backpressure");
            checkValue("backpressure accept", (i != 4 && i != robSize + 1), accepted);
        end
        guard = 0;
        accepted = 1'b0;
        while (!accepted && guard < 50) begin
            startCycle("backpressure");
            pickPending(nextRandom());
            resolveBusy(2'd0, 1'b0);
            wantDisp = 1'b1;
            instIsBranch = 1'b1;
            finishCycle("backpressure");
            guard++;
        end
        if (!accepted)
            reportFailure("backpressure", "dispatch never resumed after commits and resolutions");
    endtask

    task automatic lookupTest();
        for (int i = 0; i < 2; i++) begin
            startCycle("lookup");
            wantDisp = 1'b1;
            instReg = 4'(i + 1);
            finishCycle("lookup");
        end
        // bypass on the younger entry while the older one is still unwritten
        startCycle("lookup");
        wbValid = 1'b1;
        wbTag = rob[1].tag;
        wbData = nextRandom();
        readTagA = rob[1].tag;
        readTagB = rob[0].tag;
        finishCycle("lookup");
        startCycle("lookup");
        readTagA = rob[1].tag;
        finishCycle("lookup");
    endtask

    task automatic randomTest(input int cycles);
        logic [31:0] r;
        for (int n = 0; n < cycles; n++) begin
            startCycle("random");
            r = nextRandom();
            wantDisp = (r[1:0] != 0);
            instIsBranch = (r[4:2] == 0);
            instReg = r[8:5];
            if (r[9] || r[10])
                pickPending(nextRandom());
            if (r[13:11] == 0)
                resolveBusy(r[15:14], r[17:16] == 0);
            case (r[19:18])
                2'd0: readTagA = tagFree;
                2'd1: readTagA = wbTag;
                default: readTagA = liveTag(nextRandom());
            endcase
            readTagB = r[20] ? liveTag(r >> 21) : wbTag;
            finishCycle("random");
        end
    endtask

    initial begin
        seed = 32'h46de;
        errors = 0;
        testErrors = 0;
        testsRun = 0;
        testsFailed = 0;
        clearInputs();
        archReadReg = '0;
        archPending = 1'b0;
        busy = '0;
        tail = '0;
        for (int i = 0; i < 4; i++)
            depMask[i] = '0;
        for (int i = 0; i < 16; i++)
            regModel[i] = '0;
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        startCycle("reset");
        readTagA = '0;
        instIsBranch = 1'b1;
        #1;
        checkValue("reset commitValid", 0, commitValid);
        checkValue("reset readOkA", 0, readOkA);
        checkValue("reset instReady", 1, instReady);
        checkValue("reset issueTag", 0, issueTag);
        sweepRegs("reset");
        endTest("reset");

        backpressureTest();
        drain("backpressure");
        endTest("backpressure");

        lookupTest();
        drain("lookup");
        endTest("lookup");

        randomTest(1500);
        drain("random");
        sweepRegs("random");
        endTest("random");

        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
coreTypesPkg.sv
branchPkg.sv
robIfs.sv
dispatchUnit.sv
reorderBuffer.sv
archRegFile.sv
robCore.sv
tbRobCore.sv
